//--- sources.f
verilog/colmix_pkg.sv
verilog/colmix_layer_prio.sv
verilog/colmix_pal_ram.sv
verilog/colmix_video_out.sv
verilog/colmix_top.sv
+incdir+dv
dv/colmix_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the colour mixer testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module colmix_tb \
    -o colmix_sim || { echo "build failed"; exit 1; }

./obj_dir/colmix_sim > sim.log 2>&1
cat sim.log

grep -q "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- dv/colmix_tests.svh
////////////////////
// colour mixer directed tests
// palette access, layer order, object priority, enables,
// blanking and cpu traffic during video
////////////////////

`ifndef COLMIX_TESTS_SVH
`define COLMIX_TESTS_SVH

task automatic test_palette_access();
    logic [15:0] rd;
    cpu_write(11'h7ff, 16'hffff, 2'b11);
    cpu_write(11'h7ff, 16'h1234, 2'b01);    // low byte only
    cpu_read(11'h7ff, rd);
    check_val("cpu_rdata", rd, shadow[11'h7ff]);
    cpu_write(11'h7ff, 16'hab00, 2'b10);    // high byte only
    cpu_write(11'h7ff, 16'h0000, 2'b00);    // nothing touched
    cpu_read(11'h7ff, rd);
    check_val("cpu_rdata", rd, shadow[11'h7ff]);
    cpu_write(11'h123, 16'h5678, 2'b11);
    cpu_read(11'h123, rd);
    check_val("cpu_rdata", rd, shadow[11'h123]);
endtask

// tiles fight it out under a transparent object
task automatic test_layer_order();
    repeat (30)
        drive_pixel(4'hf, 1'b1, 1'b1, 7'($urandom), 11'($urandom), 11'($urandom),
                    {2'($urandom), 6'($urandom), 4'd0});
    flush_pixels();
endtask

task automatic test_obj_priority();
    repeat (60)
        drive_pixel(4'hf, 1'b1, 1'b1, 7'($urandom), 11'($urandom), 11'($urandom),
                    12'($urandom));
    flush_pixels();
endtask

// one layer off at a time
task automatic test_layer_enable();
    for (int b = 0; b < 4; b++) begin
        repeat (12)
            drive_pixel(~(4'd1 << b), 1'b1, 1'b1, 7'($urandom), 11'($urandom),
                        11'($urandom), 12'($urandom));
    end
    flush_pixels();
endtask

task automatic test_blanking();
    repeat (24)
        drive_pixel(4'hf, 1'($urandom), 1'($urandom), 7'($urandom), 11'($urandom),
                    11'($urandom), 12'($urandom));
    flush_pixels();
endtask

// stream stays below 0x600 while cpu writes land at 0x600 and up
task automatic test_cpu_during_video();
    fork
        repeat (50)
            drive_pixel(4'hf, 1'b1, 1'b1, 7'($urandom), {2'($urandom), 9'($urandom)},
                        {2'($urandom), 9'($urandom)}, {2'($urandom), 1'b0, 9'($urandom)});
        for (int i = 0; i < 8; i++)
            cpu_write(11'h600 + 11'(i), 16'($urandom), 2'b11);
    join
    flush_pixels();
endtask

`endif

//--- dv/colmix_tb.sv
////////////////////
// colour mixer testbench
// clock, reset, DUT, shadow palette with a model of the
// priority and colour rules, cpu and pixel drivers
////////////////////

`timescale 1ns/1ps
`default_nettype none

module colmix_tb;

    localparam int DRV_DLY = 2;     // ns after the rising edge
    localparam int TMO     = 20;    // clk edges per wait loop
    localparam int LAT     = colmix_pkg::PIX_LAT;

    logic        clk, arst_n, pxl_cen;
    logic [3:0]  gfx_en;
    logic        hblank_n, vblank_n;
    logic [6:0]  char_pxl;
    logic [10:0] scr1_pxl, scr2_pxl;
    logic [11:0] obj_pxl;
    logic        cpu_req, cpu_we, cpu_ack;
    logic [10:0] cpu_addr;
    logic [15:0] cpu_wdata, cpu_rdata;
    logic [1:0]  cpu_be;
    logic [4:0]  red, green, blue;
    logic        hblank_dly_n, vblank_dly_n;

    logic [15:0] shadow [0:2047];   // what the palette should hold
    logic [16:0] exp_q [$];         // {hb, vb, r, g, b} per pixel in flight

    colmix_top u_dut (
        .clk(clk), .arst_n(arst_n), .pxl_cen(pxl_cen), .gfx_en(gfx_en),
        .hblank_n(hblank_n), .vblank_n(vblank_n),
        .char_pxl(char_pxl), .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .obj_pxl(obj_pxl),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_be(cpu_be), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .red(red), .green(green), .blue(blue),
        .hblank_dly_n(hblank_dly_n), .vblank_dly_n(vblank_dly_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // pixel enable on every other clk once out of reset
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #DRV_DLY pxl_cen = arst_n ? ~pxl_cen : 1'b0;
        end
    end

    task automatic report_fail();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        report_fail();
    endtask

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            report_fail();
        end
    endtask

    // object over tile only when opaque, matching code, tile prio clear
    function automatic logic [10:0] obj_over(input logic [11:0] obj, input logic [9:0] tile,
                                             input logic tile_prio, input logic [1:0] code);
        if (obj[3:0] != 4'd0 && obj[11:10] == code && !tile_prio)
            return {1'b1, obj[9:0]};
        return {1'b0, tile};
    endfunction

    function automatic logic opaque_cand(input logic [10:0] cand);
        if (cand[10])
            return cand[3:0] != 4'd0;   // object half
        return cand[2:0] != 3'd0;
    endfunction

    function automatic logic [16:0] model_pixel(input logic [3:0] en, input logic hb,
            input logic vb, input logic [6:0] chr, input logic [10:0] s1,
            input logic [10:0] s2, input logic [11:0] obj);
        logic [10:0] c_chr, c_s1, c_s2, addr;
        logic [15:0] w;
        logic [14:0] rgb;
        if (!en[0]) chr[3:0] = 4'd0;
        if (!en[1]) s1[3:0]  = 4'd0;
        if (!en[2]) s2[3:0]  = 4'd0;
        if (!en[3]) obj[3:0] = 4'd0;
        c_chr = obj_over(obj, {4'd0, chr[5:0]}, chr[6], 2'd3);
        c_s1  = obj_over(obj, s1[9:0], s1[10], 2'd2);
        c_s2  = obj_over(obj, s2[9:0], s2[10], 2'd1);
        addr  = opaque_cand(c_chr) ? c_chr : (opaque_cand(c_s1) ? c_s1 : c_s2);
        w     = shadow[addr];
        rgb   = {w[3:0], w[12], w[7:4], w[13], w[11:8], w[14]};
        if (!(hb && vb))
            rgb = '0;
        return {hb, vb, rgb};
    endfunction

    // wait for a clk edge that carried a pixel enable
    task automatic next_cen();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TMO)
                timeout_fail("a pixel enable");
        end while (pxl_cen !== 1'b1);
    endtask

    task automatic check_output(input logic [16:0] e);
        check_val("hblank_dly_n", {15'd0, hblank_dly_n}, {15'd0, e[16]});
        check_val("vblank_dly_n", {15'd0, vblank_dly_n}, {15'd0, e[15]});
        check_val("red", {11'd0, red}, {11'd0, e[14:10]});
        check_val("green", {11'd0, green}, {11'd0, e[9:5]});
        check_val("blue", {11'd0, blue}, {11'd0, e[4:0]});
    endtask

    // check the pixel from LAT enables ago, then present a new one
    task automatic drive_pixel(input logic [3:0] en, input logic hb, input logic vb,
            input logic [6:0] chr, input logic [10:0] s1, input logic [10:0] s2,
            input logic [11:0] obj);
        next_cen();
        #DRV_DLY;
        if (exp_q.size() == LAT)
            check_output(exp_q.pop_front());
        gfx_en   = en;
        hblank_n = hb;
        vblank_n = vb;
        char_pxl = chr;
        scr1_pxl = s1;
        scr2_pxl = s2;
        obj_pxl  = obj;
        exp_q.push_back(model_pixel(en, hb, vb, chr, s1, s2, obj));
    endtask

    // drain pixels still in the pipeline
    task automatic flush_pixels();
        while (exp_q.size() > 0) begin
            next_cen();
            #DRV_DLY;
            check_output(exp_q.pop_front());
        end
    endtask

    // one four-phase transfer with ack latency and hold checked on the way
    task automatic cpu_access(input logic we, input logic [10:0] addr, input logic [15:0] wdata,
                              input logic [1:0] be, output logic [15:0] rdata);
        int n;
        n = 0;
        while (cpu_ack !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > TMO)
                timeout_fail("cpu_ack to clear before a request");
        end
        @(posedge clk);
        #DRV_DLY;
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_be    = be;
        n = 0;
        do begin
            @(posedge clk);
            #DRV_DLY;
            n++;
            if (n > TMO)
                timeout_fail("cpu_ack to rise");
        end while (cpu_ack !== 1'b1);
        check_val("cpu_ack rise edges", 16'(n), 16'd3);     // first edge plus two
        rdata = cpu_rdata;
        @(posedge clk);
        #DRV_DLY;
        check_val("cpu_ack", {15'd0, cpu_ack}, 16'd1);      // held while req is up
        cpu_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            #DRV_DLY;
            n++;
            if (n > TMO)
                timeout_fail("cpu_ack to fall");
        end while (cpu_ack !== 1'b0);
        check_val("cpu_ack fall edges", 16'(n), 16'd1);
    endtask

    task automatic cpu_write(input logic [10:0] addr, input logic [15:0] wdata,
                             input logic [1:0] be);
        logic [15:0] unused;
        cpu_access(1'b1, addr, wdata, be, unused);
        if (be[0]) shadow[addr][7:0]  = wdata[7:0];
        if (be[1]) shadow[addr][15:8] = wdata[15:8];
    endtask

    task automatic cpu_read(input logic [10:0] addr, output logic [15:0] rdata);
        cpu_access(1'b0, addr, 16'h0, 2'b00, rdata);
    endtask

    // fill the whole palette with a pattern spread over every address bit
    task automatic fill_palette();
        for (int a = 0; a < 2048; a++)
            cpu_write(11'(a), 16'(a * 16'h9e37) ^ 16'h35c1, 2'b11);
    endtask

    `include "colmix_tests.svh"

    // hard stop if something never finishes
    initial begin
        #60ms;
        timeout_fail("the whole run");
    end

    initial begin
        void'($urandom(32'h9c21));
        arst_n   = 1'b0;
        gfx_en   = 4'hf;
        hblank_n = 1'b0;
        vblank_n = 1'b0;
        char_pxl = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        obj_pxl  = '0;
        cpu_req  = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_be   = 2'b00;
        repeat (3) @(posedge clk);
        #DRV_DLY;
        check_val("cpu_ack", {15'd0, cpu_ack}, 16'd0);      // reset values
        check_val("red", {11'd0, red}, 16'd0);
        check_val("green", {11'd0, green}, 16'd0);
        check_val("blue", {11'd0, blue}, 16'd0);
        check_val("hblank_dly_n", {15'd0, hblank_dly_n}, 16'd0);
        check_val("vblank_dly_n", {15'd0, vblank_dly_n}, 16'd0);
        arst_n = 1'b1;
        fill_palette();
        test_palette_access();
        test_layer_order();
        test_obj_priority();
        test_layer_enable();
        test_blanking();
        test_cpu_during_video();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/colmix_top.sv
////////////////////
// colour mixer top
// layer priority, palette lookup and colour output in a
// three pixel-enable pipeline, cpu palette port alongside
////////////////////

`timescale 1ns/1ps
`default_nettype none

module colmix_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          pxl_cen,
    input  logic [3:0]                    gfx_en,
    input  logic                          hblank_n,
    input  logic                          vblank_n,
    // layer pixels
    input  logic [6:0]                    char_pxl,
    input  logic [10:0]                   scr1_pxl,
    input  logic [10:0]                   scr2_pxl,
    input  logic [11:0]                   obj_pxl,
    // cpu palette port
    input  logic                          cpu_req,
    input  logic                          cpu_we,
    input  logic [colmix_pkg::PAL_AW-1:0] cpu_addr,
    input  logic [colmix_pkg::PAL_DW-1:0] cpu_wdata,
    input  logic [1:0]                    cpu_be,
    output logic                          cpu_ack,
    output logic [colmix_pkg::PAL_DW-1:0] cpu_rdata,
    // video out
    output logic [colmix_pkg::CH_W-1:0]   red,
    output logic [colmix_pkg::CH_W-1:0]   green,
    output logic [colmix_pkg::CH_W-1:0]   blue,
    output logic                          hblank_dly_n,
    output logic                          vblank_dly_n
);

    logic [colmix_pkg::PAL_AW-1:0] pal_addr;    // visible entry, stage 1
    logic [colmix_pkg::PAL_DW-1:0] pal_word;    // looked-up word, stage 2

    colmix_layer_prio u_layer_prio (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr)
    );

    colmix_pal_ram u_pal_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .pxl_cen   (pxl_cen),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_be    (cpu_be),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .vid_addr  (pal_addr),
        .vid_word  (pal_word)
    );

    // bit 15 of the palette word carries no colour
    colmix_video_out u_video_out (
        .clk          (clk),
        .arst_n       (arst_n),
        .pxl_cen      (pxl_cen),
        .pal_word     (pal_word[colmix_pkg::RGB_W-1:0]),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n)
    );

endmodule

`default_nettype wire

//--- verilog/colmix_video_out.sv
////////////////////
// colour output
// expands the palette word to 5 bit channels, blacks out the
// blanking interval and delays the blank flags to match
////////////////////

`timescale 1ns/1ps
`default_nettype none

module colmix_video_out (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         pxl_cen,
    input  logic [colmix_pkg::RGB_W-1:0] pal_word,
    input  logic                         hblank_n,
    input  logic                         vblank_n,
    output logic [colmix_pkg::CH_W-1:0]  red,
    output logic [colmix_pkg::CH_W-1:0]  green,
    output logic [colmix_pkg::CH_W-1:0]  blue,
    output logic                         hblank_dly_n,
    output logic                         vblank_dly_n
);

    localparam int LAT = colmix_pkg::PIX_LAT;

    logic [LAT-1:0]              hblank_sr;  // one tap per pipeline stage
    logic [LAT-1:0]              vblank_sr;
    logic [colmix_pkg::CH_W-1:0] red_x, green_x, blue_x;
    logic                        active;     // blank flags of the pixel now in pal_word

    // 4 msbs then the shared lsb from the top bits
    assign red_x   = {pal_word[3:0],  pal_word[12]};
    assign green_x = {pal_word[7:4],  pal_word[13]};
    assign blue_x  = {pal_word[11:8], pal_word[14]};

    // pal_word trails the pixel inputs by LAT-1 enables
    assign active = hblank_sr[LAT-2] & vblank_sr[LAT-2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hblank_sr <= '0;
            vblank_sr <= '0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
        end else if (pxl_cen) begin
            hblank_sr <= {hblank_sr[LAT-2:0], hblank_n};
            vblank_sr <= {vblank_sr[LAT-2:0], vblank_n};
            red       <= active ? red_x   : '0;   // black in blanking
            green     <= active ? green_x : '0;
            blue      <= active ? blue_x  : '0;
        end
    end

    assign hblank_dly_n = hblank_sr[LAT-1];
    assign vblank_dly_n = vblank_sr[LAT-1];

endmodule

`default_nettype wire

//--- verilog/colmix_pal_ram.sv
////////////////////
// palette memory
// 2048 x 16 words, cpu side on a four-phase req/ack port with
// byte enables, video side read once per pixel enable
////////////////////

`timescale 1ns/1ps
`default_nettype none

module colmix_pal_ram (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          pxl_cen,
    // cpu port
    input  logic                          cpu_req,
    input  logic                          cpu_we,
    input  logic [colmix_pkg::PAL_AW-1:0] cpu_addr,
    input  logic [colmix_pkg::PAL_DW-1:0] cpu_wdata,
    input  logic [1:0]                    cpu_be,     // bit 1 = high byte
    output logic                          cpu_ack,
    output logic [colmix_pkg::PAL_DW-1:0] cpu_rdata,
    // video port
    input  logic [colmix_pkg::PAL_AW-1:0] vid_addr,
    output logic [colmix_pkg::PAL_DW-1:0] vid_word
);

    localparam int DEPTH = 2 ** colmix_pkg::PAL_AW;

    logic [colmix_pkg::PAL_DW-1:0] mem [0:DEPTH-1];

    colmix_pkg::pal_state_e state;
    logic                   cpu_acc;    // memory access cycle

    assign cpu_acc = (state == colmix_pkg::CPU_ACCESS);

    // req seen -> access -> ack, so ack rises two clk after req is sampled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= colmix_pkg::CPU_IDLE;
            cpu_ack <= 1'b0;
        end else begin
            case (state)
                colmix_pkg::CPU_IDLE: begin
                    if (cpu_req)
                        state <= colmix_pkg::CPU_ACCESS;
                end
                colmix_pkg::CPU_ACCESS: begin
                    state <= colmix_pkg::CPU_ACK;   // data settled this edge
                end
                colmix_pkg::CPU_ACK: begin
                    if (cpu_req) begin
                        cpu_ack <= 1'b1;            // hold while cpu waits
                    end else begin
                        cpu_ack <= 1'b0;            // req dropped, close handshake
                        state   <= colmix_pkg::CPU_IDLE;
                    end
                end
                default: begin
                    state   <= colmix_pkg::CPU_IDLE;
                    cpu_ack <= 1'b0;
                end
            endcase
        end
    end

    // cpu side of the array
    // address and data are held stable by the cpu during req
    always_ff @(posedge clk) begin
        if (cpu_acc) begin
            if (cpu_we) begin
                if (cpu_be[0]) mem[cpu_addr][7:0]  <= cpu_wdata[7:0];
                if (cpu_be[1]) mem[cpu_addr][15:8] <= cpu_wdata[15:8];
            end else begin
                cpu_rdata <= mem[cpu_addr];   // valid by the time ack rises
            end
        end
    end

    // video side, free running on pixel enable
    // never waits on the cpu port
    always_ff @(posedge clk) begin
        if (pxl_cen)
            vid_word <= mem[vid_addr];
    end

endmodule

`default_nettype wire

//--- verilog/colmix_layer_prio.sv
////////////////////
// layer priority
// masks disabled layers, pairs each tile layer with the object pixel
// and picks the visible palette address per pixel
////////////////////

`timescale 1ns/1ps
`default_nettype none

module colmix_layer_prio (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          pxl_cen,
    input  logic [3:0]                    gfx_en,     // char, scr1, scr2, obj
    input  logic [6:0]                    char_pxl,
    input  logic [10:0]                   scr1_pxl,
    input  logic [10:0]                   scr2_pxl,
    input  logic [11:0]                   obj_pxl,
    output logic [colmix_pkg::PAL_AW-1:0] pal_addr
);

    logic [6:0]  char_g;
    logic [10:0] scr1_g;
    logic [10:0] scr2_g;
    logic [11:0] obj_g;
    logic [colmix_pkg::PAL_AW-1:0] lyr_char, lyr_scr1, lyr_scr2;   // registered candidates

    // object wins only when opaque, at the matching code, over a low-prio tile
    function automatic logic [colmix_pkg::PAL_AW-1:0] tile_or_obj(
        input logic [9:0] obj,
        input logic [9:0] tile,
        input logic       tile_prio,
        input logic       prio_hit
    );
        logic obj_wins;
        obj_wins = (obj[3:0] != 4'd0) && prio_hit && !tile_prio;
        if (obj_wins)
            tile_or_obj = {colmix_pkg::SRC_OBJ, obj};
        else
            tile_or_obj = {colmix_pkg::SRC_TILE, tile};
    endfunction

    // objects use all 4 colour bits, tiles only 3
    function automatic logic is_opaque(input logic [colmix_pkg::PAL_AW-1:0] cand);
        colmix_pkg::lyr_src_e src;
        src = colmix_pkg::lyr_src_e'(cand[colmix_pkg::PAL_AW-1]);
        if (src == colmix_pkg::SRC_OBJ)
            is_opaque = cand[3:0] != 4'd0;
        else
            is_opaque = cand[2:0] != 3'd0;
    endfunction

    // disabled layer -> colour bits forced transparent
    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[0]) char_g[3:0] = 4'd0;
        if (!gfx_en[1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[3]) obj_g[3:0]  = 4'd0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lyr_char <= '0;
            lyr_scr1 <= '0;
            lyr_scr2 <= '0;
        end else if (pxl_cen) begin
            lyr_char <= tile_or_obj(obj_g[9:0], {4'd0, char_g[5:0]}, char_g[6],
                                    obj_g[11:10] == colmix_pkg::PRIO_CHAR);
            lyr_scr1 <= tile_or_obj(obj_g[9:0], scr1_g[9:0], scr1_g[10],
                                    obj_g[11:10] == colmix_pkg::PRIO_SCR1);
            lyr_scr2 <= tile_or_obj(obj_g[9:0], scr2_g[9:0], scr2_g[10],
                                    obj_g[11:10] == colmix_pkg::PRIO_SCR2);
        end
    end

    // front-most opaque candidate, scr2 as backdrop
    always_comb begin
        if (is_opaque(lyr_char))
            pal_addr = lyr_char;
        else if (is_opaque(lyr_scr1))
            pal_addr = lyr_scr1;
        else
            pal_addr = lyr_scr2;    // even if transparent
    end

endmodule

`default_nettype wire

//--- verilog/colmix_pkg.sv
////////////////////
// colour mixer shared definitions
// palette geometry, output widths, pixel latency and the enums
// used by the priority stage and the CPU port of the palette
////////////////////

`default_nettype none

package colmix_pkg;

    // palette geometry
    localparam int PAL_AW  = 11;    // 2048 entries
    localparam int PAL_DW  = 16;    // cpu word, top bit unused by video
    localparam int RGB_W   = 15;    // stored colour, 5 bits per channel
    localparam int CH_W    = 5;     // per channel at the output

    // pixel enables from layer inputs to colour out
    localparam int PIX_LAT = 3;

    // object priority code that lets the object cover each tile layer
    localparam logic [1:0] PRIO_CHAR = 2'd3;
    localparam logic [1:0] PRIO_SCR1 = 2'd2;
    localparam logic [1:0] PRIO_SCR2 = 2'd1;

    // cpu side of the palette, four-phase req/ack
    typedef enum logic [1:0] {
        CPU_IDLE,       // waiting for req
        CPU_ACCESS,     // memory read or byte write
        CPU_ACK         // ack held until req drops
    } pal_state_e;

    // which half of the palette a candidate points into
    // lands on bit 10 of the palette address
    typedef enum logic {
        SRC_TILE = 1'b0,
        SRC_OBJ  = 1'b1
    } lyr_src_e;

endpackage

`default_nettype wire
